// File: verilog/smc_pkg.sv
package smc_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int addr_w   = 32;   // AHB and EMI address
  localparam int data_w   = 32;   // AHB data
  localparam int mem_w    = 16;   // External data bus
  localparam int mem_be_w = 2;    // One enable per external byte

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Decoded transfer size, anything above word folds into WIDE
  typedef enum logic [2:0] {
    BYTE = 3'd0,
    HALF = 3'd1,
    WORD = 3'd2,
    WIDE = 3'd3
  } hsize_e;

  // Access sequencer states
  typedef enum logic [1:0] {
    S_IDLE   = 2'b00,
    S_LEAD   = 2'b01,   // CS low, strobes high
    S_STROBE = 2'b10,   // CS and strobe low
    S_TRAIL  = 2'b11    // Bus float before next access
  } smc_state_e;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    logic [addr_w-1:0] haddr;
    htrans_e           htrans;
    logic              hsel;
    logic              hwrite;
    logic [2:0]        hsize;    // Raw AHB size
  } ahb_req_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;     // Byte address
    hsize_e            size;
    logic              write;
    logic [data_w-1:0] wdata;    // AHB write word
  } access_req_t;

  // Pins towards the SRAM
  typedef struct packed {
    logic [addr_w-1:0]   addr;
    logic                n_cs;
    logic                n_rd;
    logic                n_we;
    logic [mem_be_w-1:0] n_be;
    logic [mem_w-1:0]    wdata;
  } emi_bus_t;

endpackage

// File: verilog/smc_ahb_if.sv
`timescale 1ns/1ps

module smc_ahb_if import smc_pkg::*; (
  input  logic              hclk,
  input  logic              reset,
  input  ahb_req_t          ahb_req,
  input  logic              hready,       // Muxed bus ready
  input  logic [data_w-1:0] hwdata,
  output access_req_t       req,
  output logic              req_valid,
  input  logic              req_ready,
  input  logic              xfer_done,    // Last strobe cycle of last access
  input  logic [data_w-1:0] rdata_word,
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output hresp_e            smc_hresp
);

  logic              accept;       // Address phase taken this cycle
  logic              wide;
  hsize_e            size_dec;
  access_req_t       new_req;
  access_req_t       req_q;        // Held transfer
  logic              first_q;      // First data-phase cycle, hwdata valid
  logic              pend_q;       // Waiting for the sequencer
  logic              err_q;        // First cycle of ERROR response
  logic              hready_q;
  hresp_e            hresp_q;
  logic [data_w-1:0] hrdata_q;

  // ------------------------------
  // Address phase decode
  // ------------------------------
  assign accept = ahb_req.hsel && hready && hready_q &&
                  (ahb_req.htrans == NONSEQ || ahb_req.htrans == SEQ);

  assign size_dec = (ahb_req.hsize > 3'd2) ? WIDE : hsize_e'(ahb_req.hsize);
  assign wide     = (size_dec == WIDE);

  always_comb begin
    new_req.addr  = ahb_req.haddr;
    new_req.size  = size_dec;
    new_req.write = ahb_req.hwrite;
    new_req.wdata = req_q.wdata;   // Real data follows one cycle later
  end

  // Bypass on accept so the sequencer can start straight away
  always_comb begin
    if (accept) begin
      req = new_req;
    end else begin
      req = req_q;
      if (first_q)
        req.wdata = hwdata;        // Merge write data in first data cycle
    end
  end

  assign req_valid = (accept && !wide) || pend_q;

  // ------------------------------
  // Response control
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      hready_q <= 1'b1;
      hresp_q  <= OKAY;
      err_q    <= 1'b0;
      first_q  <= 1'b0;
      pend_q   <= 1'b0;
    end else begin
      first_q <= 1'b0;
      if (err_q) begin              // Second ERROR cycle, ready high
        hready_q <= 1'b1;
        err_q    <= 1'b0;
      end else if (xfer_done) begin
        hready_q <= 1'b1;
      end
      if (pend_q && req_ready)
        pend_q <= 1'b0;
      if (accept) begin
        hready_q <= 1'b0;
        if (wide) begin
          hresp_q <= ERROR;
          err_q   <= 1'b1;
        end else begin
          hresp_q <= OKAY;
          first_q <= 1'b1;
          pend_q  <= !req_ready;    // Sequencer still in trail
        end
      end else if (hready_q) begin
        hresp_q <= OKAY;
      end
    end
  end

  // Transfer and read data holding
  always_ff @(posedge hclk) begin
    if (accept && !wide)
      req_q <= new_req;
    else if (first_q)
      req_q.wdata <= hwdata;
    if (xfer_done)
      hrdata_q <= rdata_word;      // Valid with ready in last cycle
  end

  assign smc_hready = hready_q;
  assign smc_hresp  = hresp_q;
  assign smc_hrdata = hrdata_q;

endmodule

// File: verilog/smc_timing_counter.sv
`timescale 1ns/1ps

module smc_timing_counter import smc_pkg::*; #(
  parameter int CSLE = 1,   // Lead cycles
  parameter int WS   = 2,   // Wait states
  parameter int CSTE = 1    // Trail cycles
) (
  input  logic       hclk,
  input  logic       reset,
  input  smc_state_e state,
  input  smc_state_e next_state,
  output logic       phase_last,   // Last cycle of current phase
  output logic       trail_skip    // No trail phase configured
);

  localparam int cnt_w = 4;

  // Reload values, counter runs down to zero
  localparam logic [cnt_w-1:0] lead_load   = (CSLE > 0) ? cnt_w'(CSLE - 1) : '0;
  localparam logic [cnt_w-1:0] strobe_load = cnt_w'(WS);
  localparam logic [cnt_w-1:0] trail_load  = (CSTE > 0) ? cnt_w'(CSTE - 1) : '0;

  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] load_val;
  logic             reload;

  always_comb begin
    case (next_state)
      S_LEAD:   load_val = lead_load;
      S_STROBE: load_val = strobe_load;
      S_TRAIL:  load_val = trail_load;
      default:  load_val = '0;
    endcase
  end

  // Phase change, or back-to-back strobes when both lead and trail are 0
  assign reload = (next_state != state) || phase_last;

  always_ff @(posedge hclk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (reload) begin
      cnt_q <= load_val;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // In idle this tells the sequencer to skip the lead phase
  assign phase_last = (state == S_IDLE) ? (CSLE == 0) : (cnt_q == '0);
  assign trail_skip = (CSTE == 0);

endmodule

// File: verilog/smc_state_ctrl.sv
`timescale 1ns/1ps

module smc_state_ctrl import smc_pkg::*; (
  input  logic       hclk,
  input  logic       reset,
  input  logic       req_valid,
  output logic       req_ready,
  input  logic       phase_last,
  input  logic       trail_skip,
  input  logic       last_access,   // Current access finishes the transfer
  output smc_state_e state,
  output smc_state_e next_state,
  output logic       xfer_done,
  output logic       smc_busy
);

  logic       more_q;        // Second halfword still to do
  logic       lead_skip_q;   // Zero lead cycles
  smc_state_e resume_state;  // Entry point of the next access

  assign resume_state = lead_skip_q ? S_STROBE : S_LEAD;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (req_valid)
          next_state = phase_last ? S_STROBE : S_LEAD;   // phase_last means no lead
      end
      S_LEAD: begin
        if (phase_last)
          next_state = S_STROBE;
      end
      S_STROBE: begin
        if (phase_last) begin
          if (!trail_skip)
            next_state = S_TRAIL;
          else if (last_access)
            next_state = S_IDLE;
          else
            next_state = resume_state;
        end
      end
      S_TRAIL: begin
        if (phase_last)
          next_state = more_q ? resume_state : S_IDLE;
      end
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (reset) begin
      state       <= S_IDLE;
      more_q      <= 1'b0;
      lead_skip_q <= 1'b0;
    end else begin
      state <= next_state;
      if (state == S_IDLE)
        lead_skip_q <= phase_last;
      if (state == S_STROBE && phase_last)
        more_q <= !last_access;   // Remember across the trail phase
    end
  end

  // ------------------------------
  // Handshake and status
  // ------------------------------
  assign req_ready = (state == S_IDLE);
  assign xfer_done = (state == S_STROBE) && phase_last && last_access;
  assign smc_busy  = (state != S_IDLE);

endmodule

// File: verilog/smc_mac.sv
`timescale 1ns/1ps

module smc_mac import smc_pkg::*; (
  input  logic                hclk,
  input  logic                reset,
  input  access_req_t         req,
  input  smc_state_e          state,
  input  smc_state_e          next_state,
  input  logic                phase_last,
  input  logic [mem_w-1:0]    data_smc,
  output logic                last_access,
  output logic                half_sel,     // Halfword of the coming access
  output logic [mem_w-1:0]    lane_wdata,
  output logic [mem_be_w-1:0] lane_n_be,
  output logic [data_w-1:0]   rdata_word
);

  logic             is_word;
  logic             strobe_end;
  logic             cnt_q;       // Access index in current transfer
  logic             cnt_d;
  logic [mem_w-1:0] low_q;       // Low read half of a word

  assign is_word    = (req.size == WORD);
  assign strobe_end = (state == S_STROBE) && phase_last;

  // Word needs two accesses, byte and half one
  assign last_access = !is_word || cnt_q;

  // ------------------------------
  // Access counter
  // ------------------------------
  always_comb begin
    cnt_d = cnt_q;
    if (next_state == S_IDLE)
      cnt_d = 1'b0;
    else if (strobe_end && !last_access)
      cnt_d = 1'b1;
  end

  always_ff @(posedge hclk) begin
    if (reset)
      cnt_q <= 1'b0;
    else
      cnt_q <= cnt_d;
  end

  // Look-ahead value, the pins are loaded on the phase edge
  assign half_sel = is_word ? cnt_d : req.addr[1];

  // ------------------------------
  // Write lanes
  // ------------------------------
  assign lane_wdata = half_sel ? req.wdata[data_w-1:mem_w] : req.wdata[mem_w-1:0];

  always_comb begin
    case (req.size)
      BYTE:    lane_n_be = req.addr[0] ? 2'b01 : 2'b10;   // Active low
      default: lane_n_be = 2'b00;
    endcase
  end

  // ------------------------------
  // Read assembly
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (strobe_end && !cnt_q)
      low_q <= data_smc;
  end

  // Narrow reads land on both halves, the master picks its lane
  assign rdata_word = is_word ? {data_smc, low_q} : {data_smc, data_smc};

endmodule

// File: verilog/smc_emi_drive.sv
`timescale 1ns/1ps

module smc_emi_drive import smc_pkg::*; (
  input  logic                hclk,
  input  logic                reset,
  input  access_req_t         req,
  input  smc_state_e          next_state,
  input  logic                half_sel,
  input  logic [mem_w-1:0]    lane_wdata,
  input  logic [mem_be_w-1:0] lane_n_be,
  output emi_bus_t            emi
);

  logic                cs_next;       // CS low in coming cycle
  logic                strobe_next;
  logic                n_cs_q;
  logic                n_rd_q;
  logic                n_we_q;
  logic [mem_be_w-1:0] n_be_q;
  logic [addr_w-1:0]   addr_q;
  logic [mem_w-1:0]    wdata_q;

  assign cs_next     = (next_state == S_LEAD) || (next_state == S_STROBE);
  assign strobe_next = (next_state == S_STROBE);

  // ------------------------------
  // Strobes, all registered
  // ------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      n_cs_q <= 1'b1;
      n_rd_q <= 1'b1;
      n_we_q <= 1'b1;
      n_be_q <= '1;
    end else begin
      n_cs_q <= !cs_next;
      n_rd_q <= !(strobe_next && !req.write);
      n_we_q <= !(strobe_next && req.write);
      n_be_q <= cs_next ? lane_n_be : '1;
    end
  end

  // Address and write data
  always_ff @(posedge hclk) begin
    if (cs_next)
      addr_q <= {req.addr[addr_w-1:2], half_sel, 1'b0};   // Halfword aligned
    if (!req.write)
      wdata_q <= '0;
    else if (cs_next)
      wdata_q <= lane_wdata;   // Reloaded each cycle, settles before strobe
  end

  assign emi = '{
    addr:  addr_q,
    n_cs:  n_cs_q,
    n_rd:  n_rd_q,
    n_we:  n_we_q,
    n_be:  n_be_q,
    wdata: wdata_q
  };

endmodule

// File: verilog/smc_top.sv
`timescale 1ns/1ps

module smc_top import smc_pkg::*; #(
  parameter int CSLE = 1,
  parameter int WS   = 2,
  parameter int CSTE = 1
) (
  input  logic              hclk,
  input  logic              reset,
  input  ahb_req_t          ahb_req,
  input  logic              hready,
  input  logic [data_w-1:0] hwdata,
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output hresp_e            smc_hresp,
  input  logic [mem_w-1:0]  data_smc,
  output emi_bus_t          emi,
  output logic              smc_busy
);

  // ------------------------------
  // Internal nets
  // ------------------------------
  access_req_t         req;
  logic                req_valid;
  logic                req_ready;
  logic                xfer_done;
  logic [data_w-1:0]   rdata_word;
  smc_state_e          state;
  smc_state_e          next_state;
  logic                phase_last;
  logic                trail_skip;
  logic                last_access;
  logic                half_sel;
  logic [mem_w-1:0]    lane_wdata;
  logic [mem_be_w-1:0] lane_n_be;

  smc_ahb_if u_ahb_if (
    .hclk       (hclk),
    .reset      (reset),
    .ahb_req    (ahb_req),
    .hready     (hready),
    .hwdata     (hwdata),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .xfer_done  (xfer_done),
    .rdata_word (rdata_word),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp)
  );

  smc_timing_counter #(
    .CSLE (CSLE),
    .WS   (WS),
    .CSTE (CSTE)
  ) u_timing_counter (
    .hclk       (hclk),
    .reset      (reset),
    .state      (state),
    .next_state (next_state),
    .phase_last (phase_last),
    .trail_skip (trail_skip)
  );

  smc_state_ctrl u_state_ctrl (
    .hclk        (hclk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .phase_last  (phase_last),
    .trail_skip  (trail_skip),
    .last_access (last_access),
    .state       (state),
    .next_state  (next_state),
    .xfer_done   (xfer_done),
    .smc_busy    (smc_busy)
  );

  smc_mac u_mac (
    .hclk        (hclk),
    .reset       (reset),
    .req         (req),
    .state       (state),
    .next_state  (next_state),
    .phase_last  (phase_last),
    .data_smc    (data_smc),
    .last_access (last_access),
    .half_sel    (half_sel),
    .lane_wdata  (lane_wdata),
    .lane_n_be   (lane_n_be),
    .rdata_word  (rdata_word)
  );

  smc_emi_drive u_emi_drive (
    .hclk       (hclk),
    .reset      (reset),
    .req        (req),
    .next_state (next_state),
    .half_sel   (half_sel),
    .lane_wdata (lane_wdata),
    .lane_n_be  (lane_n_be),
    .emi        (emi)
  );

endmodule

// File: tb/emi_sram_model.sv
`timescale 1ns/1ps

module emi_sram_model import smc_pkg::*; (
  input  logic             hclk,
  input  emi_bus_t         emi,
  output logic [mem_w-1:0] data_smc
);

  localparam int depth = 4096;   // Low 12 address bits decoded

  logic [7:0]  mem [0:depth-1];
  logic [11:0] base;             // Even byte of the halfword

  // Fill from the full address
  initial begin
    for (int i = 0; i < depth; i++)
      mem[i] = 8'(i) ^ 8'(i >> 4) ^ 8'ha5;
  end

  assign base = {emi.addr[11:1], 1'b0};

  // Byte writes under active-low enables
  always @(posedge hclk) begin
    if (!emi.n_cs && !emi.n_we) begin
      if (!emi.n_be[0])
        mem[base] <= emi.wdata[7:0];
      if (!emi.n_be[1])
        mem[base + 12'd1] <= emi.wdata[15:8];
    end
  end

  // Async read, bus floats otherwise
  assign data_smc = (!emi.n_cs && !emi.n_rd) ? {mem[base + 12'd1], mem[base]} : 'z;

endmodule

// File: tb/smc_asserts.sv
`timescale 1ns/1ps

module smc_asserts import smc_pkg::*; #(
  parameter int WS = 2
) (
  input logic     hclk,
  input logic     reset,
  input emi_bus_t emi
);

  localparam int strobe_len = WS + 1;

  logic strobe_n;       // Low while either strobe is active
  int   fail_cnt = 0;   // Broken bus rules so far

  assign strobe_n = emi.n_rd && emi.n_we;

  // ------------------------------
  // External bus rules
  // ------------------------------
  rd_we_exclusive: assert property (@(posedge hclk) disable iff (reset)
    !(!emi.n_rd && !emi.n_we))
    else begin
      $error("n_rd and n_we low together");
      fail_cnt++;
    end

  strobe_in_cs: assert property (@(posedge hclk) disable iff (reset)
    !strobe_n |-> !emi.n_cs)
    else begin
      $error("Strobe active without chip select");
      fail_cnt++;
    end

  // Strobe width fixed by wait states
  strobe_width: assert property (@(posedge hclk) disable iff (reset)
    $fell(strobe_n) |-> !strobe_n [*strobe_len] ##1 strobe_n)
    else begin
      $error("Strobe width differs from WS+1 cycles");
      fail_cnt++;
    end

endmodule

// File: tb/tb_smc.sv
`timescale 1ns/1ps

module tb_smc import smc_pkg::*; ();

  // ------------------------------
  // Timing of the DUT and the run
  // ------------------------------
  localparam int csle          = 1;
  localparam int ws            = 2;
  localparam int cste          = 1;
  localparam int access_cycles = csle + ws + 1;                    // Lead plus strobe
  localparam int clk_period    = 4;
  localparam int reset_cycles  = 16;
  localparam int est_cycles    = 2000;                             // Generous test length
  localparam int watchdog_ns   = est_cycles * clk_period * 5 / 2;  // 20 us
  localparam int max_wait      = 64;                               // Cycles per data phase

  logic              hclk;
  logic              reset;
  ahb_req_t          ahb_req;
  logic              hready;
  logic [data_w-1:0] hwdata;
  logic [data_w-1:0] smc_hrdata;
  logic              smc_hready;
  hresp_e            smc_hresp;
  logic [mem_w-1:0]  data_smc;
  emi_bus_t          emi;
  logic              smc_busy;

  integer      seed;
  logic [7:0]  ref_mem [0:4095];   // Expected SRAM bytes
  logic [31:0] cs_addr_q [$];      // Address at each n_cs fall
  logic [1:0]  be_q [$];           // n_be at each strobe start
  int          busy_cycles;
  logic        cs_prev;
  logic        stb_prev;

  smc_top #(
    .CSLE (csle),
    .WS   (ws),
    .CSTE (cste)
  ) u_smc_top (
    .hclk       (hclk),
    .reset      (reset),
    .ahb_req    (ahb_req),
    .hready     (hready),
    .hwdata     (hwdata),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .data_smc   (data_smc),
    .emi        (emi),
    .smc_busy   (smc_busy)
  );

  emi_sram_model u_sram (
    .hclk     (hclk),
    .emi      (emi),
    .data_smc (data_smc)
  );

  bind smc_top smc_asserts #(.WS(WS)) u_asserts (
    .hclk  (hclk),
    .reset (reset),
    .emi   (emi)
  );

  initial begin
    hclk = 1'b0;
    forever #(clk_period / 2) hclk = ~hclk;
  end

  initial begin
    #(watchdog_ns * 1ns);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  // ------------------------------
  // Bus monitor
  // ------------------------------
  always @(negedge hclk) begin
    if (!reset) begin
      if (cs_prev && !emi.n_cs)
        cs_addr_q.push_back(emi.addr);        // New access
      if (stb_prev && !(emi.n_rd && emi.n_we))
        be_q.push_back(emi.n_be);
      if (smc_busy)
        busy_cycles++;
      assert (emi.n_cs || smc_busy)
        else abort_run("Chip select was active while smc_busy was low");
      assert (u_smc_top.u_asserts.fail_cnt == 0)
        else abort_run("A bus protocol assertion failed");
    end
    cs_prev  = emi.n_cs;
    stb_prev = emi.n_rd && emi.n_we;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
  endtask

  // ------------------------------
  // Reference memory
  // ------------------------------
  task automatic ref_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data);
    int          nbytes;
    int          lane;
    int          i;
    logic [31:0] base;
    nbytes = 1 << size;
    base   = addr & ~(nbytes - 1);          // Naturally aligned
    for (i = 0; i < nbytes; i++) begin
      lane = (base + i) % 4;
      ref_mem[12'(base + i)] = data[8 * lane +: 8];
    end
  endtask

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [11:0] a;
    a = {addr[11:2], 2'b00};
    return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], ref_mem[a + 12'd1], ref_mem[a]};
  endfunction

  // AHB lanes used by a transfer
  function automatic logic [31:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
    case (size)
      3'd0:    return 32'h0000_00ff << (8 * addr[1:0]);
      3'd1:    return 32'h0000_ffff << (16 * addr[1]);
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic check_read(input string what, input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] got);
    logic [31:0] mask;
    mask = lane_mask(addr, size);
    check_eq(what, got & mask, ref_word(addr) & mask);
  endtask

  // ------------------------------
  // One AHB transfer with protocol checks
  // ------------------------------
  task automatic ahb_xfer(input logic write, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] wdata, input int stall, output logic [31:0] rdata);
    int          n;
    int          i;
    int          cycles;
    int          exp_cycles;
    hresp_e      first_resp;
    logic [31:0] exp_addr;
    logic [1:0]  exp_be;
    n          = (size > 3'd2) ? 0 : ((size == 3'd2) ? 2 : 1);   // External accesses
    exp_cycles = (n == 0) ? 2 : 1 + n * access_cycles + (n - 1) * cste;
    @(posedge hclk);
    cs_addr_q.delete();
    be_q.delete();
    busy_cycles = 0;
    ahb_req <= '{haddr: addr, htrans: NONSEQ, hsel: 1'b1, hwrite: write, hsize: size};
    hready  <= (stall == 0);
    for (i = 0; i < stall; i++) begin
      @(negedge hclk);
      assert (smc_hready && !smc_busy && emi.n_cs)
        else abort_run("A transfer started while hready was held low");
      @(posedge hclk);
      if (i == stall - 1)
        hready <= 1'b1;
    end
    @(posedge hclk);                  // Accept edge
    ahb_req.htrans <= IDLE;
    ahb_req.hsel   <= 1'b0;
    hwdata         <= wdata;          // First data-phase cycle
    cycles     = 0;
    first_resp = OKAY;
    do begin
      @(negedge hclk);
      cycles++;
      if (cycles == 1)
        first_resp = smc_hresp;
      assert (cycles <= max_wait)
        else abort_run("smc_hready never returned high after a transfer");
    end while (!smc_hready);
    rdata = smc_hrdata;
    check_eq("data phase cycles", cycles, exp_cycles);
    if (n == 0) begin
      check_eq("first cycle hresp", first_resp, ERROR);
      check_eq("second cycle hresp", smc_hresp, ERROR);
    end else begin
      check_eq("hresp", smc_hresp, OKAY);
    end
    check_eq("n_cs assertions", cs_addr_q.size(), n);
    check_eq("strobe count", be_q.size(), n);
    exp_be = (size == 3'd0) ? ~(2'b01 << addr[0]) : 2'b00;   // Active low
    for (i = 0; i < n; i++) begin
      exp_addr = {addr[31:2], (n == 2) ? i[0] : addr[1], 1'b0};   // Even half first
      check_eq("EMI address", cs_addr_q[i], exp_addr);
      check_eq("n_be", be_q[i], exp_be);
    end
    @(negedge hclk);                  // Trail done
    check_eq("smc_busy after transfer", smc_busy, 0);
    check_eq("busy cycles", busy_cycles, n * (access_cycles + cste));
    if (write && n != 0)
      ref_write(addr, size, wdata);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_test();
    @(negedge hclk);
    check_eq("n_cs after reset", emi.n_cs, 1);
    check_eq("n_rd after reset", emi.n_rd, 1);
    check_eq("n_we after reset", emi.n_we, 1);
    check_eq("n_be after reset", emi.n_be, 2'b11);
    check_eq("smc_hready after reset", smc_hready, 1);
    check_eq("smc_busy after reset", smc_busy, 0);
    check_eq("smc_hresp after reset", smc_hresp, OKAY);
  endtask

  task automatic word_round_trip();
    logic [31:0] addrs [$];
    logic [31:0] addr;
    logic [31:0] rdata;
    int          i;
    for (i = 0; i < 8; i++) begin
      addr = $random(seed) & 32'h0000_0ffc;
      ahb_xfer(1'b1, addr, 3'd2, $random(seed), 0, rdata);
      addrs.push_back(addr);
    end
    for (i = 0; i < 8; i++) begin
      ahb_xfer(1'b0, addrs[i], 3'd2, 32'h0, 0, rdata);
      check_read("word read", addrs[i], 3'd2, rdata);
    end
  endtask

  task automatic byte_merge();
    logic [31:0] base;
    logic [31:0] hw;
    logic [31:0] rdata;
    logic [7:0]  b [4];
    int          i;
    base = $random(seed) & 32'h0000_0ffc;
    for (i = 0; i < 4; i++) begin
      b[i] = $random(seed);
      hw   = $random(seed);            // Junk on the other lanes
      hw[8 * i +: 8] = b[i];
      ahb_xfer(1'b1, base + i, 3'd0, hw, 0, rdata);
    end
    ahb_xfer(1'b0, base, 3'd2, 32'h0, 0, rdata);
    check_eq("merged word", rdata, {b[3], b[2], b[1], b[0]});
  endtask

  task automatic halfword_lanes();
    logic [31:0] base;
    logic [31:0] hw;
    logic [31:0] rdata;
    logic [15:0] h [2];
    int          k;
    base = $random(seed) & 32'h0000_0ffc;
    for (k = 0; k < 2; k++) begin
      h[k] = $random(seed);
      hw   = $random(seed);
      hw[16 * k +: 16] = h[k];
      ahb_xfer(1'b1, base + 2 * k, 3'd1, hw, 0, rdata);
    end
    for (k = 0; k < 2; k++) begin
      ahb_xfer(1'b0, base + 2 * k, 3'd1, 32'h0, 0, rdata);
      check_eq("halfword lane", rdata[16 * k +: 16], h[k]);
    end
    ahb_xfer(1'b0, base, 3'd2, 32'h0, 0, rdata);
    check_eq("halfword pair", rdata, {h[1], h[0]});
  endtask

  task automatic error_response();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [2:0]  size;
    addr = $random(seed) & 32'h0000_0ffc;
    size = 3'd3 + 3'($unsigned($random(seed)) % 5);   // Any size above word
    ahb_xfer(1'b1, addr, size, $random(seed), 0, rdata);
    ahb_xfer(1'b1, addr, 3'd2, $random(seed), 0, rdata);   // Normal transfer after
    ahb_xfer(1'b0, addr, 3'd2, 32'h0, 0, rdata);
    check_read("word after error", addr, 3'd2, rdata);
  endtask

  task automatic stall_and_busy();
    logic [31:0] addr;
    logic [31:0] rdata;
    int          stall;
    int          i;
    for (i = 0; i < 4; i++) begin
      addr  = $random(seed) & 32'h0000_0ffc;
      stall = 1 + $unsigned($random(seed)) % 6;
      ahb_xfer(1'b1, addr, 3'd2, $random(seed), stall, rdata);
      ahb_xfer(1'b0, addr, 3'd2, 32'h0, 0, rdata);
      check_read("read after stalled write", addr, 3'd2, rdata);
    end
  endtask

  initial begin
    seed    = 32'h8cc0;
    reset   = 1'b1;
    hready  = 1'b1;
    hwdata  = '0;
    ahb_req = '0;
    repeat (reset_cycles) @(posedge hclk);
    reset <= 1'b0;
    reset_test();
    word_round_trip();
    byte_merge();
    halfword_lanes();
    error_response();
    stall_and_busy();
    if (u_smc_top.u_asserts.fail_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("A bus protocol assertion failed");
    end
  end

endmodule

// File: tb.f
verilog/smc_pkg.sv
verilog/smc_ahb_if.sv
verilog/smc_timing_counter.sv
verilog/smc_state_ctrl.sv
verilog/smc_mac.sv
verilog/smc_emi_drive.sv
verilog/smc_top.sv
tb/emi_sram_model.sv
tb/smc_asserts.sv
tb/tb_smc.sv

// File: Bender.yml
package:
  name: smc

sources:
  - verilog/smc_pkg.sv
  - verilog/smc_ahb_if.sv
  - verilog/smc_timing_counter.sv
  - verilog/smc_state_ctrl.sv
  - verilog/smc_mac.sv
  - verilog/smc_emi_drive.sv
  - verilog/smc_top.sv
  - target: simulation
    files:
      - tb/emi_sram_model.sv
      - tb/smc_asserts.sv
      - tb/tb_smc.sv
